// ==== bridge_pkg.sv ====
package bridge_pkg;

    localparam int ADDR_W = 32;                 // byte address width
    localparam int DATA_W = 32;                 // one cpu word
    localparam int STRB_W = DATA_W / 8;         // byte lanes per word
    localparam int ID_W   = 4;                  // axi id width
    localparam int LEN_W  = 8;                  // axi4 burst length field
    localparam int SIZE_W = 3;                  // axi size code field

    // read ids tell the router which port a beat belongs to
    localparam logic [ID_W-1:0] ID_DATA = 4'd1;   // data port read
    localparam logic [ID_W-1:0] ID_INST = 4'd0;   // icache line fill

    localparam int LINE_BEATS = 4;                                // words per icache line
    localparam logic [LEN_W-1:0]  INST_LEN  = LEN_W'(LINE_BEATS - 1); // axi len is beats - 1
    localparam logic [SIZE_W-1:0] SIZE_WORD = 3'd2;               // 4 bytes per beat

    typedef struct packed {
        logic              wr;      // 1 = store
        logic [1:0]        size;    // cpu size code, byte/half/word
        logic [ADDR_W-1:0] addr;
        logic [STRB_W-1:0] wstrb;   // byte enables for stores
        logic [DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [SIZE_W-1:0] size;
    } axi_ar_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic              last;    // final beat of the burst
    } axi_r_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [SIZE_W-1:0] size;
    } axi_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axi_w_t;

endpackage

// ==== axi_chan_reg.sv ====
`timescale 1ns/100ps

module axi_chan_reg #(
    parameter type payload_t = logic    // ar, aw or w payload struct
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     load,          // new request from the arbiter
    input  payload_t payload_in,
    input  logic     ready,         // subordinate side ready
    output logic     valid,
    output payload_t payload
);

    // valid flag, one entry deep
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid <= 1'b0;          // channel idle after reset
        end
        else if (load)
        begin
            valid <= 1'b1;          // shows up the cycle after load
        end
        else if (ready)
        begin
            valid <= 1'b0;          // handshake done, drop the entry
        end
    end

    // payload held steady while valid waits for ready
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            payload <= payload_in;  // only loaded when the entry is empty
        end
    end

endmodule

// ==== bridge_req_arbiter.sv ====
`timescale 1ns/100ps

module bridge_req_arbiter (
    input  logic                           clk,
    input  logic                           reset,

    // cpu data port
    input  logic                           data_req,
    input  bridge_pkg::cpu_req_t           data_in,
    output logic                           data_addr_ok,

    // icache read port
    input  logic                           icache_rd_req,
    input  logic [bridge_pkg::ADDR_W-1:0]  icache_rd_addr,
    output logic                           icache_rd_rdy,

    // completion from the response side
    input  logic                           read_done,      // last r beat taken
    input  logic                           data_data_ok,   // data txn finished

    // loads into the channel registers
    output logic                           ar_load,
    output bridge_pkg::axi_ar_t            ar_req,
    output logic                           wr_load,        // aw and w together
    output bridge_pkg::axi_aw_t            aw_req,
    output bridge_pkg::axi_w_t             w_req
);

    localparam int LINE_BYTES = bridge_pkg::LINE_BEATS * bridge_pkg::STRB_W;
    localparam logic [bridge_pkg::ADDR_W-1:0] LINE_OFS = LINE_BYTES - 1;          // line offset bits
    localparam logic [bridge_pkg::ADDR_W-1:0] WORD_OFS = bridge_pkg::STRB_W - 1;  // byte in word

    logic read_busy;        // an ar is out, waiting on its last r beat
    logic data_busy;        // a data read or write not yet acked to the cpu
    logic data_rd_req;
    logic data_wr_req;
    logic data_rd_acc;
    logic data_wr_acc;
    logic inst_acc;

    assign data_rd_req = data_req & ~data_in.wr;
    assign data_wr_req = data_req & data_in.wr;

    // data read needs both the read path and the data slot free
    assign data_rd_acc = data_rd_req & ~data_busy & ~read_busy;
    assign data_wr_acc = data_wr_req & ~data_busy;              // writes skip the read path
    // icache yields to any data read in the same cycle, as in the old bridge
    assign inst_acc    = icache_rd_req & ~read_busy & ~data_rd_req;

    assign data_addr_ok  = data_rd_acc | data_wr_acc;
    assign icache_rd_rdy = inst_acc;

    assign ar_load = data_rd_acc | inst_acc;    // never both, see priority above
    assign wr_load = data_wr_acc;

    // ar payload mux, data side first
    always_comb
    begin
        if (data_rd_req)
        begin
            ar_req.id   = bridge_pkg::ID_DATA;
            ar_req.addr = data_in.addr & ~WORD_OFS;     // word aligned
            ar_req.len  = '0;                           // single beat
            ar_req.size = {1'b0, data_in.size};
        end
        else
        begin
            ar_req.id   = bridge_pkg::ID_INST;
            ar_req.addr = icache_rd_addr & ~LINE_OFS;   // start of the line
            ar_req.len  = bridge_pkg::INST_LEN;
            ar_req.size = bridge_pkg::SIZE_WORD;
        end
    end

    // write address and data built straight from the cpu request
    always_comb
    begin
        aw_req.addr = data_in.addr;
        aw_req.size = {1'b0, data_in.size};
        w_req.data  = data_in.wdata;
        w_req.strb  = data_in.wstrb;
    end

    // read path occupancy
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            read_busy <= 1'b0;
        end
        else if (read_done)
        begin
            read_busy <= 1'b0;      // free again after the last beat
        end
        else if (ar_load)
        begin
            read_busy <= 1'b1;
        end
    end

    // data slot occupancy, one data txn at a time
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            data_busy <= 1'b0;
        end
        else if (data_data_ok)
        begin
            data_busy <= 1'b0;      // cpu has its ack
        end
        else if (data_addr_ok)
        begin
            data_busy <= 1'b1;
        end
    end

endmodule

// ==== bridge_resp_router.sv ====
`timescale 1ns/100ps

module bridge_resp_router (
    input  logic                           clk,
    input  logic                           reset,

    // axi response side
    input  bridge_pkg::axi_r_t             r,
    input  logic                           rvalid,
    input  logic                           bvalid,
    output logic                           rready,
    output logic                           bready,

    // back to the arbiter
    output logic                           read_done,

    // cpu data port return
    output logic                           data_data_ok,
    output logic [bridge_pkg::DATA_W-1:0]  data_rdata,

    // icache return
    output logic                           icache_ret_valid,
    output logic                           icache_ret_last,
    output logic [bridge_pkg::DATA_W-1:0]  icache_ret_data
);

    logic r_hs;             // r beat taken this cycle
    logic b_hs;             // write response taken this cycle
    logic data_beat;
    logic inst_beat;

    assign r_hs = rvalid & rready;
    assign b_hs = bvalid & bready;

    // steer by read id
    assign data_beat = r_hs & (r.id == bridge_pkg::ID_DATA);
    assign inst_beat = r_hs & (r.id == bridge_pkg::ID_INST);

    assign read_done = r_hs & r.last;   // single data beat also carries last

    // responses are never back-pressured, ready just comes up after reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rready <= 1'b0;
            bready <= 1'b0;
        end
        else
        begin
            rready <= 1'b1;
            bready <= 1'b1;
        end
    end

    // completion strobes, registered so they line up with the data
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            data_data_ok     <= 1'b0;
            icache_ret_valid <= 1'b0;
            icache_ret_last  <= 1'b0;
        end
        else
        begin
            data_data_ok     <= data_beat | b_hs;  // read and write acks never overlap
            icache_ret_valid <= inst_beat;         // one pulse per word
            icache_ret_last  <= inst_beat & r.last;
        end
    end

    // returned words
    always_ff @(posedge clk)
    begin
        if (data_beat)
        begin
            data_rdata <= r.data;
        end
        if (inst_beat)
        begin
            icache_ret_data <= r.data;
        end
    end

endmodule

// ==== cpu_axi_bridge.sv ====
`timescale 1ns/100ps

module cpu_axi_bridge (
    input  logic                           clk,
    input  logic                           reset,

    // cpu data port
    input  logic                           data_req,
    input  bridge_pkg::cpu_req_t           data_in,
    output logic                           data_addr_ok,
    output logic                           data_data_ok,
    output logic [bridge_pkg::DATA_W-1:0]  data_rdata,

    // icache line read port
    input  logic                           icache_rd_req,
    input  logic [bridge_pkg::ADDR_W-1:0]  icache_rd_addr,
    output logic                           icache_rd_rdy,
    output logic                           icache_ret_valid,
    output logic                           icache_ret_last,
    output logic [bridge_pkg::DATA_W-1:0]  icache_ret_data,

    // axi master
    output bridge_pkg::axi_ar_t            ar,
    output logic                           arvalid,
    input  logic                           arready,
    input  bridge_pkg::axi_r_t             r,
    input  logic                           rvalid,
    output logic                           rready,
    output bridge_pkg::axi_aw_t            aw,
    output logic                           awvalid,
    input  logic                           awready,
    output bridge_pkg::axi_w_t             w,
    output logic                           wvalid,
    input  logic                           wready,
    input  logic                           bvalid,
    output logic                           bready
);

    logic                 ar_load;
    bridge_pkg::axi_ar_t  ar_req;
    logic                 wr_load;
    bridge_pkg::axi_aw_t  aw_req;
    bridge_pkg::axi_w_t   w_req;
    logic                 read_done;

    bridge_req_arbiter arbiter (
        .clk            (clk),
        .reset          (reset),
        .data_req       (data_req),
        .data_in        (data_in),
        .data_addr_ok   (data_addr_ok),
        .icache_rd_req  (icache_rd_req),
        .icache_rd_addr (icache_rd_addr),
        .icache_rd_rdy  (icache_rd_rdy),
        .read_done      (read_done),
        .data_data_ok   (data_data_ok),
        .ar_load        (ar_load),
        .ar_req         (ar_req),
        .wr_load        (wr_load),
        .aw_req         (aw_req),
        .w_req          (w_req)
    );

    // aw and w share the load strobe but hand off on their own
    axi_chan_reg #(.payload_t(bridge_pkg::axi_ar_t)) ar_reg (
        .clk(clk), .reset(reset), .load(ar_load), .payload_in(ar_req),
        .ready(arready), .valid(arvalid), .payload(ar)
    );
    axi_chan_reg #(.payload_t(bridge_pkg::axi_aw_t)) aw_reg (
        .clk(clk), .reset(reset), .load(wr_load), .payload_in(aw_req),
        .ready(awready), .valid(awvalid), .payload(aw)
    );
    axi_chan_reg #(.payload_t(bridge_pkg::axi_w_t)) w_reg (
        .clk(clk), .reset(reset), .load(wr_load), .payload_in(w_req),
        .ready(wready), .valid(wvalid), .payload(w)
    );

    bridge_resp_router router (
        .clk              (clk),
        .reset            (reset),
        .r                (r),
        .rvalid           (rvalid),
        .bvalid           (bvalid),
        .rready           (rready),
        .bready           (bready),
        .read_done        (read_done),
        .data_data_ok     (data_data_ok),
        .data_rdata       (data_rdata),
        .icache_ret_valid (icache_ret_valid),
        .icache_ret_last  (icache_ret_last),
        .icache_ret_data  (icache_ret_data)
    );

endmodule

// ==== cpu_axi_bridge_tb.sv ====
`timescale 1ns/100ps

module cpu_axi_bridge_tb;

    localparam int PERIOD         = 100;
    localparam int MEM_WORDS      = 256;            // byte addr bits 9:2
    localparam logic [31:0] FILL_PATTERN = 32'hA5C3_1E70;
    localparam int TIMEOUT_CYCLES = 6000;           // 150 txns at ~30 cycles, plus margin

    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
    } pend_t;                                       // data txn awaiting data_data_ok

    logic clk;
    logic reset;
    logic data_req;
    bridge_pkg::cpu_req_t data_in;
    logic data_addr_ok;
    logic data_data_ok;
    logic [31:0] data_rdata;
    logic icache_rd_req;
    logic [31:0] icache_rd_addr;
    logic icache_rd_rdy;
    logic icache_ret_valid;
    logic icache_ret_last;
    logic [31:0] icache_ret_data;
    bridge_pkg::axi_ar_t ar;
    bridge_pkg::axi_r_t  r;
    bridge_pkg::axi_aw_t aw;
    bridge_pkg::axi_w_t  w;
    logic arvalid, arready, rvalid, rready, awvalid, awready;
    logic wvalid, wready, bvalid, bready;

    logic [31:0] mem [MEM_WORDS];                   // subordinate storage
    logic [31:0] shadow [MEM_WORDS];                // what the cpu should see
    pend_t       data_q[$];
    logic [31:0] inst_q[$];                         // line base addresses in flight
    integer seed = 71;
    int mismatches = 0;
    int failures = 0;
    int done_cnt = 0;                               // data_data_ok pulses seen
    int inst_beat = 0;
    int cycles = 0;

    cpu_axi_bridge uut (
        .clk(clk), .reset(reset), .data_req(data_req), .data_in(data_in),
        .data_addr_ok(data_addr_ok), .data_data_ok(data_data_ok), .data_rdata(data_rdata),
        .icache_rd_req(icache_rd_req), .icache_rd_addr(icache_rd_addr),
        .icache_rd_rdy(icache_rd_rdy), .icache_ret_valid(icache_ret_valid),
        .icache_ret_last(icache_ret_last), .icache_ret_data(icache_ret_data),
        .ar(ar), .arvalid(arvalid), .arready(arready), .r(r), .rvalid(rvalid),
        .rready(rready), .aw(aw), .awvalid(awvalid), .awready(awready), .w(w),
        .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return shadow[addr[9:2]];
    endfunction

    function automatic void apply_write(input logic [31:0] addr, input logic [3:0] strb,
                                        input logic [31:0] wdata);
        for (int b = 0; b < 4; b++)
            if (strb[b])
                shadow[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];   // only enabled lanes
    endfunction

    function automatic int unsigned rand_delay();
        return $unsigned($random(seed)) % 4;                    // 0 to 3 cycles
    endfunction

    function automatic logic [31:0] rand_addr(input logic upper);
        return {22'd0, upper, 9'($random(seed))};               // upper half or lower half
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic fail(input string what);
        $display("ERROR at %0t: %s", $time, what);
        failures++;
    endtask

    // cpu data request, returns once accepted
    task automatic data_access(input logic wr, input logic [31:0] addr, input logic [3:0] strb,
                               input logic [31:0] wdata);
        @(negedge clk);
        data_in  = '{wr: wr, size: 2'd2, addr: addr, wstrb: strb, wdata: wdata};
        data_req = 1'b1;
        #10;                                        // let the accept settle
        while (data_addr_ok !== 1'b1)
        begin
            @(negedge clk);
            #10;
        end
        data_q.push_back('{wr: wr, addr: addr});
        if (wr)
            apply_write(addr, strb, wdata);
        @(negedge clk);
        data_req = 1'b0;
    endtask

    task automatic icache_read(input logic [31:0] addr);
        @(negedge clk);
        icache_rd_addr = addr;
        icache_rd_req  = 1'b1;
        #10;
        while (icache_rd_rdy !== 1'b1)
        begin
            @(negedge clk);
            #10;
        end
        inst_q.push_back({addr[31:4], 4'h0});       // 16 byte line
        @(negedge clk);
        icache_rd_req = 1'b0;
    endtask

    task automatic wait_idle();
        while (data_q.size() != 0 || inst_q.size() != 0)
            @(negedge clk);
    endtask

    // read side of the subordinate, one burst at a time
    initial
    begin : read_slave
        bridge_pkg::axi_ar_t held;
        forever
        begin
            @(negedge clk);
            if (arvalid === 1'b1)
            begin
                held = ar;
                check("ar size", held.size, 2);             // both ports read whole words
                check("ar word offset", held.addr[1:0], 0);
                repeat (rand_delay())
                begin
                    @(negedge clk);
                    if (arvalid !== 1'b1)
                        fail("arvalid dropped before arready");
                    check("ar payload held", ar, held);
                end
                arready = 1'b1;
                @(negedge clk);
                arready = 1'b0;
                for (int beat = 0; beat <= held.len; beat++)
                begin
                    repeat (rand_delay()) @(negedge clk);
                    r = '{id: held.id, data: mem[held.addr[9:2] + beat], last: beat == held.len};
                    rvalid = 1'b1;                  // rready is always up
                    if (rready !== 1'b1)
                        fail("rready low while an r beat is offered");
                    @(negedge clk);
                    rvalid = 1'b0;
                end
            end
        end
    end

    // write side, aw and w taken independently then one b
    initial
    begin : write_slave
        bridge_pkg::axi_aw_t aw_held;
        bridge_pkg::axi_w_t  w_held;
        forever
        begin
            fork
                begin
                    @(negedge clk);
                    while (awvalid !== 1'b1) @(negedge clk);
                    aw_held = aw;
                    check("aw size", aw_held.size, 2);
                    repeat (rand_delay())
                    begin
                        @(negedge clk);
                        if (awvalid !== 1'b1)
                            fail("awvalid dropped before awready");
                        check("aw payload held", aw, aw_held);
                    end
                    awready = 1'b1;
                    @(negedge clk);
                    awready = 1'b0;
                end
                begin
                    @(negedge clk);
                    while (wvalid !== 1'b1) @(negedge clk);
                    w_held = w;
                    repeat (rand_delay())
                    begin
                        @(negedge clk);
                        if (wvalid !== 1'b1)
                            fail("wvalid dropped before wready");
                        check("w payload held", w, w_held);
                    end
                    wready = 1'b1;
                    @(negedge clk);
                    wready = 1'b0;
                end
            join
            for (int b = 0; b < 4; b++)
                if (w_held.strb[b])
                    mem[aw_held.addr[9:2]][8*b +: 8] = w_held.data[8*b +: 8];
            repeat (rand_delay()) @(negedge clk);
            bvalid = 1'b1;
            if (bready !== 1'b1)
                fail("bready low while a write response is offered");
            @(negedge clk);
            bvalid = 1'b0;
        end
    end

    // compare returned words against the reference
    always @(negedge clk)
    begin : compare
        pend_t ent;
        if (reset === 1'b0 && data_data_ok === 1'b1)
        begin
            if (data_q.size() == 0)
                fail("data_data_ok pulsed with no data request outstanding");
            else
            begin
                ent = data_q.pop_front();
                if (!ent.wr)
                    check($sformatf("data read %h", ent.addr), data_rdata,
                          expected_word(ent.addr));
                done_cnt++;
            end
        end
        if (reset === 1'b0 && icache_ret_valid === 1'b1)
        begin
            if (inst_q.size() == 0)
                fail("icache word returned with no line read outstanding");
            else
            begin
                check($sformatf("icache word %0d", inst_beat), icache_ret_data,
                      expected_word(inst_q[0] + 4 * inst_beat));
                if ((inst_beat == bridge_pkg::LINE_BEATS - 1) != (icache_ret_last === 1'b1))
                    fail($sformatf("icache_ret_last wrong on word %0d of the line", inst_beat));
                inst_beat++;
                if (inst_beat == bridge_pkg::LINE_BEATS)
                begin
                    inst_beat = 0;
                    void'(inst_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] a;
        int base;
        reset = 1'b1;
        data_req = 1'b0;
        data_in = '0;
        icache_rd_req = 1'b0;
        icache_rd_addr = '0;
        arready = 1'b0;
        r = '0;
        rvalid = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem[i]    = i ^ FILL_PATTERN;
            shadow[i] = i ^ FILL_PATTERN;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (2)
        begin
            @(negedge clk);
            check("arvalid idle", arvalid, 0);
            check("awvalid idle", awvalid, 0);
            check("wvalid idle", wvalid, 0);
            check("data_data_ok idle", data_data_ok, 0);
            check("icache_ret_valid idle", icache_ret_valid, 0);
        end
        repeat (40)
        begin
            a = rand_addr(1'b0);
            data_access(1'b1, a, 4'($random(seed)), $random(seed));
            data_access(1'b0, a, 4'h0, 32'h0);      // read back the merged word
        end
        repeat (10) icache_read(rand_addr(1'($random(seed))));
        repeat (10)
        begin
            wait_idle();
            base = done_cnt;
            fork
                data_access(1'b0, rand_addr(1'b0), 4'h0, 32'h0);
                icache_read(rand_addr(1'b1));
                begin
                    @(negedge clk);
                    #10;
                    check("data_addr_ok on tie", data_addr_ok, 1);
                    check("icache_rd_rdy on tie", icache_rd_rdy, 0);
                    while (icache_rd_rdy !== 1'b1)
                    begin
                        @(negedge clk);
                        #10;
                    end
                    if (done_cnt == base)
                        fail("icache request accepted before the data read finished");
                end
            join
        end
        repeat (10)
        begin
            wait_idle();
            a = rand_addr(1'b0);
            data_access(1'b1, a, 4'($random(seed)), $random(seed));
            icache_read(rand_addr(1'b1));           // line fill under the pending write
            data_access(1'b0, a, 4'h0, 32'h0);
        end
        wait_idle();
        repeat (4) @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== cpu_axi_bridge.f ====
bridge_pkg.sv
axi_chan_reg.sv
bridge_req_arbiter.sv
bridge_resp_router.sv
cpu_axi_bridge.sv
cpu_axi_bridge_tb.sv
